// ==== hw/post_pkg.sv ====
`default_nettype none

package post_pkg;

    //////////////////////////////////////////////////
    // Memory geometry.
    //////////////////////////////////////////////////

    localparam int burst_words = 4;          // Words per SDRAM burst.

    typedef logic [15:0] word_t;             // One SDRAM word.
    typedef logic [23:0] addr_t;             // Bank(2) + row(13) + column(9).
    typedef word_t [burst_words-1:0] burst_t; // Word 0 sits in the low slice.
    typedef logic [7:0] byte_t;              // One UART payload.

    // Request toward the memory port.
    typedef struct packed {
        logic   write;                       // 1 = write, 0 = read.
        addr_t  addr;                        // First word of the burst.
        burst_t data;                        // Write data, ignored on reads.
    } mem_req_t;

    // Hand-off from the tester to the checker.
    typedef struct packed {
        burst_t expected;                    // Pattern that was written.
        burst_t actual;                      // Burst read back.
        logic   last;                        // Final burst of the run.
    } check_item_t;

    //////////////////////////////////////////////////
    // UART stream.
    //////////////////////////////////////////////////

    localparam byte_t mark_high = 8'hEE;     // Sent in a bad high-byte slot.
    localparam byte_t mark_low  = 8'hFF;     // Sent in a bad low-byte slot.

    localparam int uart_stop_bits = 2;

    //////////////////////////////////////////////////
    // State encodings.
    //////////////////////////////////////////////////

    typedef enum logic [2:0] {
        ts_write,                            // Present write request.
        ts_wait_write,                       // Wait for write completion.
        ts_read,                             // Present read request.
        ts_wait_read,                        // Wait for read data.
        ts_hand_off,                         // Offer burst to the checker.
        ts_dwell,                            // Pause before next burst.
        ts_stopped                           // End of run or error.
    } tester_state_e;

    typedef enum logic [2:0] {
        cs_idle,                             // Ready for a new item.
        cs_compare,                          // Check one byte slot.
        cs_send,                             // Offer byte to the UART.
        cs_halted,                           // Mismatch seen.
        cs_finished                          // Last burst passed.
    } checker_state_e;

endpackage

`default_nettype wire

// ==== hw/uart_tx.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_tx #(
    parameter int unsigned baud_div = 1157        // Clocks per bit.
) (
    input  logic            clk_133MHz_210,
    input  logic            rst_n,

    input  post_pkg::byte_t tx_byte,
    input  logic            tx_valid,
    output logic            tx_ready,             // High between frames only.

    output logic            uart_txd
);

    import post_pkg::*;

    localparam int frame_bits = 1 + $bits(byte_t) + uart_stop_bits; // Start, data, stop.
    localparam int bit_w      = $clog2(frame_bits);
    localparam int baud_w     = $clog2(baud_div + 1);

    logic                  busy_q;
    logic [frame_bits-1:0] frame_q;               // Shifted out LSB first.
    logic [baud_w-1:0]     baud_cnt_q;
    logic [bit_w-1:0]      bit_cnt_q;
    logic                  accept;
    logic                  bit_end;

    assign tx_ready = !busy_q;
    assign accept   = tx_valid && !busy_q;
    assign bit_end  = (baud_cnt_q == baud_w'(baud_div - 1));
    assign uart_txd = busy_q ? frame_q[0] : 1'b1; // Idle line is high.

    //////////////////////////////////////////////////
    // Baud and bit counters.
    //////////////////////////////////////////////////

    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            busy_q     <= 1'b0;
            baud_cnt_q <= '0;
            bit_cnt_q  <= '0;
        end else if (accept) begin
            busy_q     <= 1'b1;
            baud_cnt_q <= '0;
            bit_cnt_q  <= '0;
        end else if (busy_q) begin
            if (bit_end) begin
                baud_cnt_q <= '0;
                if (bit_cnt_q == bit_w'(frame_bits - 1)) begin
                    busy_q <= 1'b0;                 // Last stop bit done.
                end else begin
                    bit_cnt_q <= bit_cnt_q + 1'b1;
                end
            end else begin
                baud_cnt_q <= baud_cnt_q + 1'b1;
            end
        end
    end

    // Frame shift register.
    always_ff @(posedge clk_133MHz_210) begin
        if (accept) begin
            frame_q <= {{uart_stop_bits{1'b1}}, tx_byte, 1'b0};
        end else if (busy_q && bit_end) begin
            frame_q <= {1'b1, frame_q[frame_bits-1:1]}; // Next bit to the line.
        end
    end

endmodule

`default_nettype wire

// ==== hw/word_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module word_checker (
    input  logic                  clk_133MHz_210,
    input  logic                  rst_n,

    // Bursts from the tester.
    input  post_pkg::check_item_t item,
    input  logic                  item_valid,
    output logic                  item_ready,

    // Byte stream to the UART.
    output post_pkg::byte_t       tx_byte,
    output logic                  tx_valid,
    input  logic                  tx_ready,

    output logic                  fail,           // Sticky until reset.
    output logic                  done            // Whole run passed.
);

    import post_pkg::*;

    localparam int slots  = 2 * burst_words;      // High and low byte per word.
    localparam int slot_w = $clog2(slots);

    checker_state_e    state_q;
    check_item_t       item_q;                    // Burst under test.
    logic [slot_w-1:0] slot_q;                    // Current byte slot.
    logic              mismatch_q;                // Slot holds a marker byte.
    byte_t             byte_q;
    word_t             act_word;
    word_t             exp_word;
    logic              high_slot;

    assign act_word  = item_q.actual[slot_q[slot_w-1:1]];
    assign exp_word  = item_q.expected[slot_q[slot_w-1:1]];
    assign high_slot = !slot_q[0];                // Even slots carry the high byte.

    assign item_ready = (state_q == cs_idle);
    assign tx_valid   = (state_q == cs_send);
    assign tx_byte    = byte_q;
    assign fail       = (state_q == cs_halted);
    assign done       = (state_q == cs_finished);

    //////////////////////////////////////////////////
    // Slot walk.
    //////////////////////////////////////////////////

    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= cs_idle;
            slot_q     <= '0;
            mismatch_q <= 1'b0;
        end else begin
            unique case (state_q)
                cs_idle: begin
                    if (item_valid) begin
                        slot_q  <= '0;
                        state_q <= cs_compare;
                    end
                end
                cs_compare: begin
                    mismatch_q <= (act_word != exp_word); // Whole word compared.
                    state_q    <= cs_send;
                end
                cs_send: begin
                    if (tx_ready) begin
                        if (mismatch_q) begin
                            state_q <= cs_halted;           // Marker is out.
                        end else if (slot_q == slot_w'(slots - 1)) begin
                            state_q <= item_q.last ? cs_finished : cs_idle;
                        end else begin
                            slot_q  <= slot_q + 1'b1;
                            state_q <= cs_compare;
                        end
                    end
                end
                cs_halted: begin
                    state_q <= cs_halted;
                end
                cs_finished: begin
                    state_q <= cs_finished;
                end
                default: begin
                    state_q <= cs_halted;
                end
            endcase
        end
    end

    // Payload capture and byte select.
    always_ff @(posedge clk_133MHz_210) begin
        if ((state_q == cs_idle) && item_valid) begin
            item_q <= item;
        end
        if (state_q == cs_compare) begin
            if (act_word == exp_word) begin
                byte_q <= high_slot ? act_word[15:8] : act_word[7:0];
            end else begin
                byte_q <= high_slot ? mark_high : mark_low; // Error marker.
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/burst_tester.sv ====
`timescale 1ns/100ps
`default_nettype none

module burst_tester #(
    parameter int unsigned     dwell_cycles = 2222222,
    parameter post_pkg::addr_t last_addr    = 24'd383996
) (
    input  logic                  clk_133MHz_210,
    input  logic                  rst_n,

    // Memory port.
    output post_pkg::mem_req_t    mem_req,
    output logic                  mem_req_valid,
    input  logic                  mem_req_ready,
    input  logic                  mem_rsp_valid,
    input  post_pkg::burst_t      mem_rsp_data,

    // Hand-off to the checker.
    output post_pkg::check_item_t item,
    output logic                  item_valid,
    input  logic                  item_ready,

    input  logic                  fail            // Halt request from the checker.
);

    import post_pkg::*;

    tester_state_e state_q;
    addr_t         addr_q;                        // Current burst address.
    word_t         pattern_q;                     // Value in every word of the burst.
    logic [31:0]   dwell_cnt_q;
    burst_t        actual_q;                      // Read-back data.
    burst_t        pattern_burst;
    logic          last_burst;
    logic          req_fire;
    logic          dwell_end;
    logic          started_q;                     // Low in reset and the cycle after.

    //////////////////////////////////////////////////
    // Request and hand-off outputs.
    //////////////////////////////////////////////////

    assign pattern_burst = {burst_words{pattern_q}};
    assign last_burst    = (addr_q == last_addr);

    // No new request once an error is flagged.
    assign mem_req_valid = ((state_q == ts_write) || (state_q == ts_read)) &&
                           started_q && !fail;
    assign req_fire      = mem_req_valid && mem_req_ready;

    assign mem_req.write = (state_q == ts_write);
    assign mem_req.addr  = addr_q;
    assign mem_req.data  = pattern_burst;         // Don't care on reads.

    assign item_valid    = (state_q == ts_hand_off);
    assign item.expected = pattern_burst;
    assign item.actual   = actual_q;
    assign item.last     = last_burst;

    assign dwell_end = (dwell_cnt_q >= 32'(dwell_cycles) - 32'd1);

    // Request port stays quiet until the first clock out of reset.
    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            started_q <= 1'b0;
        end else begin
            started_q <= 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Burst sequence.
    //////////////////////////////////////////////////

    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            state_q     <= ts_write;
            addr_q      <= '0;
            pattern_q   <= '0;
            dwell_cnt_q <= '0;
        end else if (fail) begin
            state_q <= ts_stopped;                // Error freezes the sequence.
        end else begin
            unique case (state_q)
                ts_write: begin
                    if (req_fire) begin
                        state_q <= ts_wait_write;
                    end
                end
                ts_wait_write: begin
                    if (mem_rsp_valid) begin
                        state_q <= ts_read;       // Write acknowledged.
                    end
                end
                ts_read: begin
                    if (req_fire) begin
                        state_q <= ts_wait_read;
                    end
                end
                ts_wait_read: begin
                    if (mem_rsp_valid) begin
                        state_q <= ts_hand_off;   // Item valid next cycle.
                    end
                end
                ts_hand_off: begin
                    // Checker may still be busy with the previous burst.
                    if (item_ready) begin
                        dwell_cnt_q <= '0;
                        if (last_burst) begin
                            state_q <= ts_stopped;
                        end else begin
                            state_q <= ts_dwell;
                        end
                    end
                end
                ts_dwell: begin
                    if (dwell_end) begin
                        dwell_cnt_q <= '0;
                        addr_q      <= addr_q + addr_t'(burst_words); // Next burst.
                        pattern_q   <= pattern_q + word_t'(1);        // Next pattern.
                        state_q     <= ts_write;
                    end else begin
                        dwell_cnt_q <= dwell_cnt_q + 32'd1;
                    end
                end
                ts_stopped: begin
                    state_q <= ts_stopped;
                end
                default: begin
                    state_q <= ts_stopped;
                end
            endcase
        end
    end

    // Capture read data.
    always_ff @(posedge clk_133MHz_210) begin
        if ((state_q == ts_wait_read) && mem_rsp_valid) begin
            actual_q <= mem_rsp_data;
        end
    end

endmodule

`default_nettype wire

// ==== hw/post_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module post_top #(
    parameter int unsigned    baud_div     = 1157,       // 133.33 MHz / 115200 baud.
    parameter int unsigned    dwell_cycles = 2222222,    // Pause between bursts.
    parameter post_pkg::addr_t last_addr   = 24'd383996  // Address of the final burst.
) (
    input  logic               clk_133MHz_210,
    input  logic               rst_n,

    // Memory request/response port.
    output post_pkg::mem_req_t mem_req,
    output logic               mem_req_valid,
    input  logic               mem_req_ready,
    input  logic               mem_rsp_valid,
    input  post_pkg::burst_t   mem_rsp_data,

    output logic               uart_txd,                 // Serial report.
    output logic               led,                      // Lit on failure.
    output logic               done                      // High after a clean run.
);

    import post_pkg::*;

    //////////////////////////////////////////////////
    // Internal links.
    //////////////////////////////////////////////////

    check_item_t item;           // Tester to checker.
    logic        item_valid;
    logic        item_ready;

    byte_t       tx_byte;        // Checker to UART.
    logic        tx_valid;
    logic        tx_ready;

    logic        fail;           // Sticky error from the checker.

    burst_tester #(
        .dwell_cycles (dwell_cycles),
        .last_addr    (last_addr)
    ) u_burst_tester (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .mem_req        (mem_req),
        .mem_req_valid  (mem_req_valid),
        .mem_req_ready  (mem_req_ready),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp_data   (mem_rsp_data),
        .item           (item),
        .item_valid     (item_valid),
        .item_ready     (item_ready),
        .fail           (fail)
    );

    word_checker u_word_checker (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .item           (item),
        .item_valid     (item_valid),
        .item_ready     (item_ready),
        .tx_byte        (tx_byte),
        .tx_valid       (tx_valid),
        .tx_ready       (tx_ready),
        .fail           (fail),
        .done           (done)
    );

    uart_tx #(
        .baud_div (baud_div)
    ) u_uart_tx (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .tx_byte        (tx_byte),
        .tx_valid       (tx_valid),
        .tx_ready       (tx_ready),
        .uart_txd       (uart_txd)
    );

    assign led = fail;           // Error lamp.

endmodule

`default_nettype wire

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
    input  logic restart,                   // Rising edge starts a new reset.
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;              // 4 ns period.
    end

    initial begin
        rst_n = 1'b0;                       // Power-on reset.
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
    end

    always @(posedge restart) begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);          // Two cycles low.
        #1 rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== sim/sdram_model.sv ====
`timescale 1ns/100ps
`default_nettype none

module sdram_model (
    input  logic               clk,
    input  logic               rst_n,
    input  post_pkg::mem_req_t mem_req,
    input  logic               mem_req_valid,
    output logic               mem_req_ready,
    output logic               mem_rsp_valid,
    output post_pkg::burst_t   mem_rsp_data,
    input  logic               stall,          // Holds ready low this cycle.
    input  logic [3:0]         latency,        // Cycles from request to response.
    input  logic               corrupt_en,
    input  post_pkg::addr_t    corrupt_addr,   // Burst that gets a bad word.
    input  logic [1:0]         corrupt_word
);

    import post_pkg::*;

    burst_t     mem [0:63];                    // Indexed by burst number.
    logic       busy;
    logic [3:0] cnt;
    logic [5:0] idx_q;

    assign mem_req_ready = rst_n && !busy && !stall;

    always @(posedge clk or negedge rst_n) begin : access
        burst_t wdata;
        if (!rst_n) begin
            busy          <= 1'b0;
            cnt           <= '0;
            mem_rsp_valid <= 1'b0;
        end else begin
            mem_rsp_valid <= 1'b0;
            if (mem_req_valid && mem_req_ready) begin
                busy  <= 1'b1;
                cnt   <= latency;
                idx_q <= mem_req.addr[7:2];
                if (mem_req.write) begin
                    wdata = mem_req.data;
                    if (corrupt_en && (mem_req.addr == corrupt_addr)) begin
                        wdata[corrupt_word] = wdata[corrupt_word] ^ 16'h8000; // Flip MSB.
                    end
                    mem[mem_req.addr[7:2]] <= wdata;
                end
            end else if (busy) begin
                if (cnt == 4'd0) begin
                    mem_rsp_valid <= 1'b1;     // One pulse per request.
                    mem_rsp_data  <= mem[idx_q];
                    busy          <= 1'b0;
                end else begin
                    cnt <= cnt - 4'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== sim/post_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module post_tb;

    import post_pkg::*;

    localparam int unsigned baud_div     = 8;
    localparam int unsigned dwell_cycles = 20;
    localparam addr_t       last_addr    = 24'd28;
    localparam int          bursts       = 8;
    localparam int          frame_ns     = 11 * baud_div * 4;
    localparam int          watchdog_ns  = 2 * bursts * 8 * frame_ns + 20000; // Two runs.

    logic       clk;
    logic       rst_n;
    logic       restart;
    mem_req_t   mem_req;
    logic       mem_req_valid;
    logic       mem_req_ready;
    logic       mem_rsp_valid;
    burst_t     mem_rsp_data;
    logic       uart_txd;
    logic       led;
    logic       done;
    logic       stall;
    logic [3:0] latency;
    logic       corrupt_en;
    addr_t      corrupt_addr;
    logic [1:0] corrupt_word;

    logic [31:0] seed = 32'h4eaa;
    int          value_errors;
    int          other_errors;
    int          req_idx;
    mem_req_t    exp_req;
    byte_t       rx_q[$];                          // Bytes seen on the line.
    byte_t       exp_q[$];                         // Predicted stream.

    tb_clock_gen clock_gen (.restart(restart), .clk(clk), .rst_n(rst_n));

    sdram_model memory (
        .clk(clk), .rst_n(rst_n), .mem_req(mem_req), .mem_req_valid(mem_req_valid),
        .mem_req_ready(mem_req_ready), .mem_rsp_valid(mem_rsp_valid),
        .mem_rsp_data(mem_rsp_data), .stall(stall), .latency(latency),
        .corrupt_en(corrupt_en), .corrupt_addr(corrupt_addr), .corrupt_word(corrupt_word)
    );

    post_top #(
        .baud_div(baud_div), .dwell_cycles(dwell_cycles), .last_addr(last_addr)
    ) uut (
        .clk_133MHz_210(clk), .rst_n(rst_n), .mem_req(mem_req),
        .mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready),
        .mem_rsp_valid(mem_rsp_valid), .mem_rsp_data(mem_rsp_data),
        .uart_txd(uart_txd), .led(led), .done(done)
    );

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    task automatic check_byte(input string name, input byte_t exp, input byte_t act);
        if (exp !== act) begin
            $display("Fail %s expected %02h actual %02h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_req(input string name, input mem_req_t exp, input mem_req_t act);
        if (exp !== act) begin
            $display("Fail %s expected %h actual %h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("Fail %s expected %b actual %b", name, exp, act);
            value_errors++;
        end
    endtask

    // Byte stream model; bad_burst < 0 means a clean run.
    task automatic build_expected(input int bad_burst, input int bad_word);
        word_t n;
        exp_q.delete();
        for (int b = 0; b < bursts; b++) begin
            n = word_t'(b);
            for (int w = 0; w < burst_words; w++) begin
                if ((b == bad_burst) && (w == bad_word)) begin
                    exp_q.push_back(8'hEE);        // Marker in the high slot.
                    return;
                end
                exp_q.push_back(n[15:8]);
                exp_q.push_back(n[7:0]);
            end
        end
    endtask

    task automatic compare_stream(input string phase);
        if (rx_q.size() != exp_q.size()) begin
            $display("%s run received %0d bytes but %0d were expected",
                     phase, rx_q.size(), exp_q.size());
            other_errors++;
        end
        for (int i = 0; i < rx_q.size() && i < exp_q.size(); i++) begin
            check_byte($sformatf("%s byte %0d", phase, i), exp_q[i], rx_q[i]);
        end
    endtask

    task automatic check_reset_outputs(input string when);
        check_bit({"uart_txd ", when}, 1'b1, uart_txd);
        check_bit({"led ", when}, 1'b0, led);
        check_bit({"done ", when}, 1'b0, done);
        check_bit({"mem_req_valid ", when}, 1'b0, mem_req_valid);
    endtask

    //////////////////////////////////////////////////
    // Random memory timing.
    //////////////////////////////////////////////////

    always @(posedge clk) begin : timing_drive
        logic [31:0] r;
        #1;
        r       = lcg_next();
        stall   = (r[31:30] == 2'b00);         // About one stall in four.
        latency = 4'(r[29:27]) + 4'd1;
    end

    //////////////////////////////////////////////////
    // Request monitor.
    //////////////////////////////////////////////////

    always @(negedge clk) begin
        if (!rst_n) begin
            req_idx = 0;
        end else begin
            if (led && mem_req_valid) begin
                $display("A memory request was raised after the fail LED lit");
                other_errors++;
            end
            if (mem_req_valid && mem_req_ready) begin
                exp_req.write = (req_idx % 2 == 0);          // Write, then read.
                exp_req.addr  = addr_t'((req_idx / 2) * 4);
                exp_req.data  = {burst_words{word_t'(req_idx / 2)}};
                check_req($sformatf("request %0d", req_idx), exp_req, mem_req);
                req_idx++;
            end
        end
    end

    //////////////////////////////////////////////////
    // UART receiver, samples mid-bit.
    //////////////////////////////////////////////////

    initial begin : uart_rx
        byte_t b;
        forever begin
            @(negedge clk);
            if (rst_n && !uart_txd) begin
                repeat (baud_div / 2) @(negedge clk);
                if (uart_txd !== 1'b0) begin
                    $display("Start bit was not low in its middle");
                    other_errors++;
                end
                for (int i = 0; i < 8; i++) begin
                    repeat (baud_div) @(negedge clk);
                    b[i] = uart_txd;               // LSB first.
                end
                for (int s = 0; s < 2; s++) begin
                    repeat (baud_div) @(negedge clk);
                    if (uart_txd !== 1'b1) begin
                        $display("Stop bit %0d was not high", s);
                        other_errors++;
                    end
                end
                rx_q.push_back(b);
            end
        end
    end

    initial begin
        #(watchdog_ns * 1ns);
        $display("Watchdog expired before the tests finished");
        $display("Result: FAILED");
        $finish;
    end

    //////////////////////////////////////////////////
    // Test sequence.
    //////////////////////////////////////////////////

    initial begin : main
        logic [31:0] r;
        int          bad_burst;
        int          bad_word;
        restart      = 1'b0;
        stall        = 1'b0;
        latency      = 4'd1;
        corrupt_en   = 1'b0;
        corrupt_addr = '0;
        corrupt_word = '0;
        value_errors = 0;
        other_errors = 0;

        #2 check_reset_outputs("during reset");
        @(posedge rst_n);
        @(negedge clk);
        check_reset_outputs("after reset");

        // Clean run.
        build_expected(-1, 0);
        while (!done) @(negedge clk);
        while (rx_q.size() < exp_q.size()) @(negedge clk);
        repeat (2 * 11 * baud_div) @(negedge clk); // Nothing extra may follow.
        compare_stream("clean");
        check_bit("led after clean run", 1'b0, led);
        check_bit("done after clean run", 1'b1, done);
        if (req_idx != 2 * bursts) begin
            $display("Clean run issued %0d requests instead of %0d", req_idx, 2 * bursts);
            other_errors++;
        end

        // Corrupted run.
        r            = lcg_next();
        bad_burst    = int'(r[31:16]) % bursts;
        bad_word     = int'(r[29:28]);
        corrupt_addr = addr_t'(bad_burst * 4);
        corrupt_word = 2'(bad_word);
        corrupt_en   = 1'b1;
        build_expected(bad_burst, bad_word);
        rx_q.delete();
        @(posedge clk);
        #1 restart = 1'b1;
        @(negedge clk);
        restart = 1'b0;
        check_reset_outputs("during second reset");
        @(posedge rst_n);
        while (!led) @(negedge clk);
        repeat (3 * 11 * baud_div) @(negedge clk); // Marker frame drains.
        compare_stream("corrupt");
        check_bit("led after corruption", 1'b1, led);
        check_bit("done after corruption", 1'b0, done);

        $display("Errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
hw/post_pkg.sv
hw/uart_tx.sv
hw/word_checker.sv
hw/burst_tester.sv
hw/post_top.sv
sim/tb_clock_gen.sv
sim/sdram_model.sv
sim/post_tb.sv

// ==== Makefile ====
# Verilator build for the SDRAM power-on self-test.

VERILATOR ?= verilator
VFLAGS    ?= --timing -j 0
TOP       ?= post_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Result: PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
